/* i8080_tests.txt */
// One test: program length, program bytes from address 0000,
// port write count then port/value pairs, memory write count then address/value pairs
// A length of 0000 ends the list
// Test 1: MVI and MOV
0015
06 22 0E 33 78 D3 01 79 D3 02 50 2E 5A 65 7C D3 03 7A D3 04 76
0004 01 22 02 33 03 5A 04 22
0000
// Test 2: register ALU ops, flags seen through jumps
0054
3E 3C 06 C8 80 D3 10 DA 0F 00 3E EE C3 11 00 3E 01 D3 11
3E 10 88 D3 12 FA 20 00 3E EE C3 22 00 3E 01 D3 13
3E 50 90 D3 14 EA 31 00 3E EE C3 33 00 3E 01 D3 15
3E 05 98 D3 16 3E F0 0E 3C A1 D3 17 D2 49 00 3E EE C3 4B 00 3E 01 D3 18
A9 D3 19 B0 D3 1A 76
000B 10 04 11 01 12 D9 13 01 14 88 15 01 16 3C 17 30 18 01 19 3D 1A FD
0000
// Test 3: immediate ops and compare
0043
3E 40 C6 C0 CA 0C 00 3E EE C3 0E 00 3E 01 D3 20
3E 10 CE 05 D3 21 D6 20 D3 22 DE 06 D3 23 E6 0F D3 24
EE FF D3 25 F6 05 D3 26 FE F5 D3 27 C2 FF 00 06 F6 B8 D3 28
DA 3E 00 3E EE C3 40 00 3E 01 D3 29 76
000A 20 01 21 16 22 F6 23 EF 24 0F 25 F0 26 F5 27 F5 28 F5 29 01
0000
// Test 4: INR and DCR wrap and keep carry
0031
3E FF C6 01 06 FF 04 78 D3 30 DA 12 00 3E EE C3 14 00 3E 01 D3 31
0E 00 0D 79 D3 32 FE 00 3C D3 33 D2 29 00 3E EE C3 2B 00 3E 01 D3 34
3D D3 35 76
0006 30 00 31 01 32 FF 33 00 34 01 35 00
0000
// Test 5: STA and LDA
001C
3E A5 32 34 12 3E 00 3A 34 12 D3 40 3E 5C 32 00 80
3A 34 12 D3 41 3A 00 80 D3 42 76
0003 40 A5 41 A5 42 5C
0002 1234 A5 8000 5C
// Test 6: nothing runs after HLT
0009
00 3E 77 D3 50 76 D3 51 76
0001 50 77
0000
// End of list
0000

/* verilog.f */
cpu_pkg.sv
bus_pkg.sv
alu.sv
reg_file.sv
cpu_control.sv
i8080_core.sv
tb_i8080.sv

/* run_sim.sh */
#!/bin/sh
# Build the core and testbench with Verilator, run, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_i8080 -f verilog.f -o sim_i8080 \
    > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_i8080 > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && exit 0 || exit 1

/* tb_i8080.sv */
/*
 * Testbench for the 8080 subset core
 * Runs the programs of the tests file and checks port and memory writes
 */
`timescale 1ns/1ps
`default_nettype none

module tb_i8080;

    logic        clk;
    logic        reset;
    logic [7:0]  data;
    logic [15:0] addr;
    logic [7:0]  w_data;
    logic        read_mem;
    logic        write_mem;
    logic        write_port;
    logic        hlt;

    logic [7:0]  mem [0:65535];
    logic [15:0] tests [0:1023];    // Stimulus words from the tests file

    logic [7:0]  port_addr_q [$];
    logic [7:0]  port_val_q [$];
    logic [15:0] mem_addr_q [$];
    logic [7:0]  mem_val_q [$];

    int   ptr;
    int   test_num;
    int   tests_failed;
    int   stray_strobes;
    int   bad_cycles;
    logic hlt_dropped;
    logic prev_hlt;
    logic hung;

    i8080_core #(
        .RESET_PC(16'h0000)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .data      (data),
        .addr      (addr),
        .w_data    (w_data),
        .read_mem  (read_mem),
        .write_mem (write_mem),
        .write_port(write_port),
        .hlt       (hlt)
    );

    assign data = mem[addr];    // Memory answers in the same cycle

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Strobes are stable mid cycle, so record them on the falling edge
    always @(negedge clk)
    begin
        if (!reset)
            prev_hlt = 1'b0;
        else
        begin
            if (write_mem)
            begin
                mem[addr] = w_data;
                mem_addr_q.push_back(addr);
                mem_val_q.push_back(w_data);
            end
            if (write_port)
            begin
                port_addr_q.push_back(addr[7:0]);
                port_val_q.push_back(w_data);
            end
            if (hlt && (read_mem || write_mem || write_port))
                stray_strobes++;
            if (!hlt && $countones({read_mem, write_mem, write_port}) != 1)
                bad_cycles++;   // Every running cycle is one fetch, read or write
            if (prev_hlt && !hlt)
                hlt_dropped = 1'b1;
            prev_hlt = hlt;
        end
    end

    // Load the next program and run it until the core halts
    task automatic run_program(output logic timed_out);
        int n_prog;
        int cycles;
        @(posedge clk);
        #1 reset = 1'b0;
        for (int a = 0; a < 65536; a++)
            mem[a] = a[7:0] ^ a[15:8] ^ 8'h5a;
        n_prog = int'(tests[ptr]);
        ptr++;
        for (int i = 0; i < n_prog; i++)
        begin
            mem[i] = tests[ptr][7:0];
            ptr++;
        end
        port_addr_q.delete();
        port_val_q.delete();
        mem_addr_q.delete();
        mem_val_q.delete();
        stray_strobes = 0;
        bad_cycles    = 0;
        hlt_dropped   = 1'b0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b1;
        cycles = 0;
        while (!hlt && cycles < 2000)
        begin
            @(negedge clk);
            cycles++;
        end
        timed_out = !hlt;
        if (!timed_out)
        begin
            repeat (20) @(negedge clk);  // Watch the bus while halted
            #1;
        end
    endtask

    task automatic check_results();
        int         n_port;
        int         n_mem;
        int         errs;
        logic [15:0] exp_a;
        logic [7:0]  exp_v;
        errs   = 0;
        n_port = int'(tests[ptr]);
        ptr++;
        if (port_addr_q.size() != n_port)
        begin
            $display("error at %0t: test %0d has %0d port writes, expected %0d",
                     $time, test_num, port_addr_q.size(), n_port);
            errs++;
        end
        for (int i = 0; i < n_port; i++)
        begin
            exp_a = tests[ptr];
            exp_v = tests[ptr + 1][7:0];
            ptr   = ptr + 2;
            if (i < port_addr_q.size())
            begin
                if (port_addr_q[i] != exp_a[7:0] || port_val_q[i] != exp_v)
                begin
                    $display("error at %0t: test %0d port write %0d is %h/%h, expected %h/%h",
                             $time, test_num, i, port_addr_q[i], port_val_q[i],
                             exp_a[7:0], exp_v);
                    errs++;
                end
            end
        end
        n_mem = int'(tests[ptr]);
        ptr++;
        if (mem_addr_q.size() != n_mem)
        begin
            $display("error at %0t: test %0d has %0d memory writes, expected %0d",
                     $time, test_num, mem_addr_q.size(), n_mem);
            errs++;
        end
        for (int i = 0; i < n_mem; i++)
        begin
            exp_a = tests[ptr];
            exp_v = tests[ptr + 1][7:0];
            ptr   = ptr + 2;
            if (i < mem_addr_q.size())
            begin
                if (mem_addr_q[i] != exp_a || mem_val_q[i] != exp_v)
                begin
                    $display("error at %0t: test %0d memory write %0d is %h/%h, expected %h/%h",
                             $time, test_num, i, mem_addr_q[i], mem_val_q[i], exp_a, exp_v);
                    errs++;
                end
            end
        end
        if (bad_cycles != 0)
        begin
            $display("Test %0d: %0d running cycles had no single bus strobe",
                     test_num, bad_cycles);
            errs++;
        end
        if (stray_strobes != 0)
        begin
            $display("Test %0d: the bus kept strobing after HLT", test_num);
            errs++;
        end
        if (hlt_dropped)
        begin
            $display("Test %0d: hlt went low again without a reset", test_num);
            errs++;
        end
        if (errs == 0)
            $display("test %0d: ok", test_num);
        else
        begin
            $display("test %0d: %0d errors", test_num, errs);
            tests_failed++;
        end
    endtask

    initial
    begin
        reset        = 1'b0;
        prev_hlt     = 1'b0;
        hlt_dropped  = 1'b0;
        hung         = 1'b0;
        ptr          = 0;
        test_num     = 0;
        tests_failed = 0;
        for (int i = 0; i < 1024; i++)
            tests[i] = 16'h0000;
        $readmemh("i8080_tests.txt", tests);
        while (!hung && ptr < 1000 && !$isunknown(tests[ptr]) && tests[ptr] != 16'h0000)
        begin
            test_num++;
            run_program(hung);
            if (hung)
            begin
                $display("Test %0d: the core never reached HLT", test_num);
                tests_failed++;
            end
            else
                check_results();
        end
        $display("tests run %0d, passed %0d, failed %0d",
                 test_num, test_num - tests_failed, tests_failed);
        if (tests_failed == 0 && test_num > 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* i8080_core.sv */
/*
 * 8080 subset core top level
 * Connects controller, register file and ALU to the external bus
 */
`timescale 1ns/1ps
`default_nettype none

module i8080_core #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  data,
    output logic [15:0] addr,
    output logic [7:0]  w_data,
    output logic        read_mem,
    output logic        write_mem,
    output logic        write_port,
    output logic        hlt
);
    import cpu_pkg::*;
    import bus_pkg::*;

    bus_req_t   bus;
    alu_op_t    alu_op;
    reg_num_t   rd_sel;
    reg_num_t   wr_sel;
    flags_t     flags;
    flags_t     alu_flags;
    flags_t     flags_mask;
    logic [7:0] alu_a;
    logic [7:0] alu_b;
    logic [7:0] alu_result;
    logic [7:0] rd_data;
    logic [7:0] acc;
    logic [7:0] ctrl_wr_data;
    logic [7:0] rf_wr_data;
    logic       wr_en;
    logic       flags_en;

    // INR and DCR work on the selected register, all else on A
    assign alu_a      = (alu_op == alu_inr || alu_op == alu_dcr) ? rd_data : acc;
    assign rf_wr_data = (alu_op == alu_none) ? ctrl_wr_data : alu_result;

    cpu_control #(
        .RESET_PC(RESET_PC)
    ) control_i (
        .clk       (clk),
        .reset     (reset),
        .data      (data),
        .bus       (bus),
        .hlt       (hlt),
        .alu_op    (alu_op),
        .alu_b     (alu_b),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data),
        .acc       (acc),
        .flags     (flags),
        .wr_en     (wr_en),
        .flags_en  (flags_en),
        .wr_sel    (wr_sel),
        .wr_data   (ctrl_wr_data),
        .flags_mask(flags_mask)
    );

    reg_file regs_i (
        .clk       (clk),
        .reset     (reset),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data),
        .acc       (acc),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel),
        .wr_data   (rf_wr_data),
        .flags_en  (flags_en),
        .flags_mask(flags_mask),
        .new_flags (alu_flags),
        .flags     (flags)
    );

    alu alu_i (
        .op      (alu_op),
        .a       (alu_a),
        .b       (alu_b),
        .carry_in(flags.c),
        .result  (alu_result),
        .flags   (alu_flags)
    );

    assign addr       = bus.addr;
    assign w_data     = bus.wdata;
    assign read_mem   = bus.read_mem;
    assign write_mem  = bus.write_mem;
    assign write_port = bus.write_port;

endmodule

`default_nettype wire

/* cpu_control.sv */
/*
 * 8080 controller: fetch, decode and execute FSM with the program
 * counter, opcode latch and address latch. Drives the external bus request
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_control #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        data,
    output bus_pkg::bus_req_t bus,
    output logic              hlt,
    output cpu_pkg::alu_op_t  alu_op,
    output logic [7:0]        alu_b,
    output cpu_pkg::reg_num_t rd_sel,
    input  logic [7:0]        rd_data,
    input  logic [7:0]        acc,
    input  cpu_pkg::flags_t   flags,
    output logic              wr_en,
    output logic              flags_en,
    output cpu_pkg::reg_num_t wr_sel,
    output logic [7:0]        wr_data,
    output cpu_pkg::flags_t   flags_mask
);
    import cpu_pkg::*;
    import bus_pkg::*;

    typedef enum logic [2:0] {
        st_fetch, st_operand, st_addr_lo, st_addr_hi, st_mem, st_port, st_halt
    } state_t;

    state_t      state;
    logic [15:0] pc;
    logic [15:0] addr_latch;
    opcode_t     ir;
    opcode_t     cur;
    bus_op_t     bus_op;
    logic        cond_ok;

    logic is_mov, is_alu_reg, is_incdec, is_mvi, is_alu_imm, is_jcc;
    logic is_lda, is_sta, is_jmp, is_out, is_hlt;

    // Opcode is live on the bus during fetch, latched afterwards
    assign cur = (state == st_fetch) ? opcode_t'(data) : ir;

    assign is_hlt     = (cur == HLT);
    assign is_mov     = (cur.group == 2'b01) && (cur.mid != 3'b110) && (cur.low != 3'b110);
    assign is_alu_reg = (cur.group == 2'b10) && (cur.low != 3'b110);
    assign is_incdec  = (cur.group == 2'b00) && (cur.low[2:1] == 2'b10) && (cur.mid != 3'b110);
    assign is_mvi     = (cur.group == 2'b00) && (cur.low == 3'b110) && (cur.mid != 3'b110);
    assign is_alu_imm = (cur.group == 2'b11) && (cur.low == 3'b110);
    assign is_jcc     = (cur.group == 2'b11) && (cur.low == 3'b010);
    assign is_lda     = (cur == LDA);
    assign is_sta     = (cur == STA);
    assign is_jmp     = (cur == JMP);
    assign is_out     = (cur == OUT);

    always_comb
    begin
        case (cond_t'(cur.mid))
            cond_nz: cond_ok = !flags.z;
            cond_z:  cond_ok = flags.z;
            cond_nc: cond_ok = !flags.c;
            cond_c:  cond_ok = flags.c;
            cond_po: cond_ok = !flags.p;
            cond_pe: cond_ok = flags.p;
            cond_p:  cond_ok = !flags.s;
            default: cond_ok = flags.s;
        endcase
    end

    // Register file and ALU strobes
    always_comb
    begin
        alu_op     = alu_none;
        alu_b      = rd_data;
        rd_sel     = reg_a;
        wr_en      = 1'b0;
        wr_sel     = reg_a;
        wr_data    = data;
        flags_en   = 1'b0;
        flags_mask = '1;
        case (state)
            st_fetch:
            begin
                if (is_mov)
                begin
                    rd_sel  = reg_num_t'(cur.low);
                    wr_en   = 1'b1;
                    wr_sel  = reg_num_t'(cur.mid);
                    wr_data = rd_data;
                end
                else if (is_alu_reg)
                begin
                    rd_sel   = reg_num_t'(cur.low);
                    alu_op   = alu_op_t'({1'b0, cur.mid});
                    wr_en    = (cur.mid != 3'b111);    // CMP leaves A alone
                    flags_en = 1'b1;
                end
                else if (is_incdec)
                begin
                    rd_sel       = reg_num_t'(cur.mid);
                    alu_op       = cur.low[0] ? alu_dcr : alu_inr;
                    wr_en        = 1'b1;
                    wr_sel       = reg_num_t'(cur.mid);
                    flags_en     = 1'b1;
                    flags_mask.c = 1'b0;
                end
            end
            st_operand:
            begin
                if (is_mvi)
                begin
                    wr_en  = 1'b1;
                    wr_sel = reg_num_t'(cur.mid);
                end
                else if (is_alu_imm)
                begin
                    alu_op   = alu_op_t'({1'b0, cur.mid});
                    alu_b    = data;
                    wr_en    = (cur.mid != 3'b111);
                    flags_en = 1'b1;
                end
            end
            st_mem: wr_en = is_lda;    // LDA result into A
            default: ;
        endcase
    end

    always_comb
    begin
        case (state)
            st_fetch:                         bus_op = bus_fetch;
            st_operand, st_addr_lo, st_addr_hi: bus_op = bus_operand;
            st_mem:   bus_op = is_sta ? bus_mem_write : bus_mem_read;
            st_port:  bus_op = bus_port_out;
            default:  bus_op = bus_idle;
        endcase
    end

    assign bus.addr       = (bus_op == bus_fetch || bus_op == bus_operand) ? pc : addr_latch;
    assign bus.wdata      = acc;
    assign bus.read_mem   = (bus_op == bus_fetch) || (bus_op == bus_operand) ||
                            (bus_op == bus_mem_read);
    assign bus.write_mem  = (bus_op == bus_mem_write);
    assign bus.write_port = (bus_op == bus_port_out);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state <= st_fetch;
            pc    <= RESET_PC;
            hlt   <= 1'b0;
        end
        else
        begin
            case (state)
                st_fetch:
                begin
                    pc <= pc + 16'h0001;
                    if (is_hlt)
                    begin
                        hlt   <= 1'b1;
                        state <= st_halt;
                    end
                    else if (is_mvi || is_alu_imm || is_out)
                        state <= st_operand;
                    else if (is_lda || is_sta || is_jmp || (is_jcc && cond_ok))
                        state <= st_addr_lo;
                    else if (is_jcc)
                        pc <= pc + 16'h0003;    // Step over the target address
                end
                st_operand:
                begin
                    pc    <= pc + 16'h0001;
                    state <= is_out ? st_port : st_fetch;
                end
                st_addr_lo:
                begin
                    pc    <= pc + 16'h0001;
                    state <= st_addr_hi;
                end
                st_addr_hi:
                begin
                    if (is_jmp || is_jcc)
                    begin
                        pc    <= {data, addr_latch[7:0]};
                        state <= st_fetch;
                    end
                    else
                    begin
                        pc    <= pc + 16'h0001;
                        state <= st_mem;
                    end
                end
                st_mem, st_port: state <= st_fetch;
                st_halt: state <= st_halt;    // Left only through reset
                default: state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            st_fetch:   ir <= data;
            st_operand: addr_latch <= {8'h00, data};    // Port number for OUT
            st_addr_lo: addr_latch[7:0] <= data;
            st_addr_hi: addr_latch[15:8] <= data;
            default: ;
        endcase
    end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!reset)
        !(bus.read_mem && bus.write_mem))
        else $error("cpu_control: read_mem and write_mem high together");

endmodule

`default_nettype wire

/* reg_file.sv */
/*
 * Register file: B, C, D, E, H, L and A plus the flag register
 * Writes and flag updates are strobed by the controller
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::reg_num_t rd_sel,
    output logic [7:0]        rd_data,
    output logic [7:0]        acc,
    input  logic              wr_en,
    input  cpu_pkg::reg_num_t wr_sel,
    input  logic [7:0]        wr_data,
    input  logic              flags_en,
    input  cpu_pkg::flags_t   flags_mask,
    input  cpu_pkg::flags_t   new_flags,
    output cpu_pkg::flags_t   flags
);
    import cpu_pkg::*;

    logic [7:0] regs [0:6];

    // A sits in the slot that M would use
    function automatic logic [2:0] slot(input reg_num_t r);
        return (r == reg_a) ? 3'd6 : r;
    endfunction

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            for (int i = 0; i < 7; i++)
                regs[i] <= 8'h00;
            flags <= '0;
        end
        else
        begin
            if (wr_en)
                regs[slot(wr_sel)] <= wr_data;
            if (flags_en)   // Masked flags keep their value
                flags <= flags_t'((flags & ~flags_mask) | (new_flags & flags_mask));
        end
    end

    assign rd_data = regs[slot(rd_sel)];
    assign acc     = regs[6];

endmodule

`default_nettype wire

/* alu.sv */
/*
 * 8080 ALU, purely combinational
 * Add, subtract and logic ops with S, Z, AC, P and C generation
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_t op,
    input  logic [7:0]       a,
    input  logic [7:0]       b,
    input  logic             carry_in,
    output logic [7:0]       result,
    output cpu_pkg::flags_t  flags
);
    import cpu_pkg::*;

    logic [8:0] full;   // Bit 8 is carry or borrow
    logic [4:0] nib;    // Bit 4 is the half carry

    always_comb
    begin
        full = {1'b0, b};
        nib  = 5'h00;
        case (op)
            alu_add:
            begin
                full = {1'b0, a} + {1'b0, b};
                nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]};
            end
            alu_adc:
            begin
                full = {1'b0, a} + {1'b0, b} + {8'h00, carry_in};
                nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'h0, carry_in};
            end
            alu_sub, alu_cmp:
            begin
                full = {1'b0, a} - {1'b0, b};
                nib  = {1'b0, a[3:0]} - {1'b0, b[3:0]};
            end
            alu_sbb:
            begin
                full = {1'b0, a} - {1'b0, b} - {8'h00, carry_in};
                nib  = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'h0, carry_in};
            end
            alu_and: full = {1'b0, a & b};
            alu_xor: full = {1'b0, a ^ b};
            alu_or:  full = {1'b0, a | b};
            alu_inr:
            begin
                full = {1'b0, a} + 9'h001;
                nib  = {1'b0, a[3:0]} + 5'h01;
            end
            alu_dcr:
            begin
                full = {1'b0, a} - 9'h001;
                nib  = {1'b0, a[3:0]} - 5'h01;
            end
            default: full = {1'b0, b};  // Pass b through when idle
        endcase
    end

    assign result   = full[7:0];
    assign flags.s  = full[7];
    assign flags.z  = (full[7:0] == 8'h00);
    assign flags.ac = nib[4];
    assign flags.p  = ~^full[7:0];  // Even parity
    assign flags.c  = full[8];      // Always zero for the logic ops

    // The controller builds op from opcode fields, so check it stays in range
    always_comb
    begin
        a_op_legal: assert (op inside {[alu_add : alu_none]})
            else $error("alu: illegal operation code %0d", op);
    end

endmodule

`default_nettype wire

/* bus_pkg.sv */
/*
 * External bus definitions: the kind of cycle the core runs and the
 * request it drives onto the memory and port strobes
 */
`default_nettype none

package bus_pkg;

    typedef enum logic [2:0] {
        bus_fetch,      // Opcode read at pc
        bus_operand,    // Immediate or address byte at pc
        bus_mem_read,
        bus_mem_write,
        bus_port_out,
        bus_idle
    } bus_op_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        read_mem;
        logic        write_mem;
        logic        write_port;
    } bus_req_t;

endpackage

`default_nettype wire

/* cpu_pkg.sv */
/*
 * 8080 instruction set definitions: register numbers, ALU operations,
 * branch conditions, flag layout and the opcode field split
 */
`default_nettype none

package cpu_pkg;

    typedef enum logic [2:0] {
        reg_b = 3'd0,
        reg_c = 3'd1,
        reg_d = 3'd2,
        reg_e = 3'd3,
        reg_h = 3'd4,
        reg_l = 3'd5,
        reg_a = 3'd7   // Code 6 is M, not implemented
    } reg_num_t;

    // Values 0..7 match the opcode mid field of the ALU group
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_adc  = 4'd1,
        alu_sub  = 4'd2,
        alu_sbb  = 4'd3,
        alu_and  = 4'd4,
        alu_xor  = 4'd5,
        alu_or   = 4'd6,
        alu_cmp  = 4'd7,
        alu_inr  = 4'd8,
        alu_dcr  = 4'd9,
        alu_none = 4'd10
    } alu_op_t;

    typedef enum logic [2:0] {
        cond_nz, cond_z, cond_nc, cond_c, cond_po, cond_pe, cond_p, cond_m
    } cond_t;

    typedef struct packed {
        logic s;
        logic z;
        logic ac;
        logic p;
        logic c;
    } flags_t;

    typedef struct packed {
        logic [1:0] group;
        logic [2:0] mid;    // Destination, ALU op or condition
        logic [2:0] low;    // Source register or sub-opcode
    } opcode_t;

    localparam logic [7:0] HLT = 8'h76;
    localparam logic [7:0] NOP = 8'h00;
    localparam logic [7:0] LDA = 8'h3a;
    localparam logic [7:0] STA = 8'h32;
    localparam logic [7:0] JMP = 8'hc3;
    localparam logic [7:0] OUT = 8'hd3;

endpackage

`default_nettype wire
